// File: hdl/lg_pkg.sv
//////////////////////////////
// logic generator package
// register map, bit positions and FSM state type
//////////////////////////////
`default_nettype none

package lg_pkg;

  //////////////////////////////
  // register offsets, byte address
  localparam logic [7:0] REG_CTL     = 8'h00;  // wr pulses, rd status
  localparam logic [7:0] REG_IRQ_ENA = 8'h08;
  localparam logic [7:0] REG_IRQ_STS = 8'h0c;  // write 1 to clear
  localparam logic [7:0] REG_SIZ     = 8'h20;  // table size in entries
  localparam logic [7:0] REG_OFF     = 8'h24;  // start offset, fixed point
  localparam logic [7:0] REG_STE     = 8'h28;  // step, fixed point
  localparam logic [7:0] REG_BCF     = 8'h30;
  localparam logic [7:0] REG_BDL     = 8'h34;
  localparam logic [7:0] REG_BNM     = 8'h3c;
  localparam logic [7:0] REG_BLN     = 8'h40;  // read only
  localparam logic [7:0] REG_BCN     = 8'h44;  // read only
  localparam logic [7:0] REG_MSK     = 8'h50;
  localparam logic [7:0] REG_VAL     = 8'h54;
  localparam logic [11:0] TBL_BASE   = 12'h100;  // table words from here up

  // REG_CTL write bits
  localparam int unsigned CTL_RST = 0;
  localparam int unsigned CTL_STR = 1;
  localparam int unsigned CTL_STP = 2;
  localparam int unsigned CTL_TRG = 3;

  // REG_CTL read bits
  localparam int unsigned STS_RUN = 0;
  localparam int unsigned STS_ARM = 1;
  localparam int unsigned STS_DON = 2;

  // interrupt enable/status bits
  localparam int unsigned IRQ_TRG = 0;
  localparam int unsigned IRQ_LST = 1;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ARMED,
    ST_RUN,
    ST_DONE
  } lg_state_t;

endpackage

`default_nettype wire

// File: hdl/lg_regs.sv
//////////////////////////////
// logic generator registers
// apb decode, config, control pulses, irq
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lg_regs #(
  parameter int unsigned DW  = 8,
  parameter int unsigned TAW = 6,
  parameter int unsigned FRW = 8,
  parameter int unsigned BNW = 16
) (
  input  logic                   bus,
  input  logic                   ctl_rst,
  input  logic [11:0]            paddr,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [31:0]            pwdata,
  output logic [31:0]            prdata,
  output logic                   pready,
  output logic                   pslverr,
  output logic                   irq,
  output logic                   ctl_str,
  output logic                   ctl_stp,
  output logic                   ctl_trg,
  output logic                   sw_rst,
  output logic [TAW:0]           cfg_siz,
  output logic [TAW+FRW-1:0]     cfg_off,
  output logic [TAW+FRW-1:0]     cfg_ste,
  output logic [BNW-1:0]         cfg_bdl,
  output logic                   cfg_ben,
  output logic                   cfg_inf,
  output logic [BNW-1:0]         cfg_bnm,
  output logic [DW-1:0]          cfg_msk,
  output logic [DW-1:0]          cfg_val,
  output logic                   tbl_we,
  output logic [TAW-1:0]         tbl_addr,
  output logic [DW-1:0]          tbl_wdata,
  input  logic [DW-1:0]          tbl_rdata,
  input  lg_pkg::lg_state_t      sts_state,
  input  logic [BNW-1:0]         sts_bln,
  input  logic [BNW-1:0]         sts_bcn,
  input  logic                   evn_trg,
  input  logic                   evn_lst
);
  import lg_pkg::*;

  logic       tbl_sel;  // address in table range
  logic       reg_wr;   // register write, access phase
  logic [1:0] irq_ena;
  logic [1:0] irq_sts;
  logic [1:0] evn;      // events in irq bit order

  assign pready  = 1'b1;  // no wait states
  assign pslverr = 1'b0;

  assign tbl_sel   = (paddr >= TBL_BASE);
  assign reg_wr    = psel && penable && pwrite && !tbl_sel;
  assign tbl_we    = psel && penable && pwrite && tbl_sel;
  assign tbl_addr  = paddr[TAW+1:2];  // word index
  assign tbl_wdata = pwdata[DW-1:0];

  //////////////////////////////
  // configuration
  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      irq_ena <= '0;
      cfg_siz <= '0;
      cfg_off <= '0;
      cfg_ste <= '0;
      cfg_ben <= 1'b0;
      cfg_inf <= 1'b0;
      cfg_bdl <= '0;
      cfg_bnm <= '0;
      cfg_msk <= '1;  // table passes through by default
      cfg_val <= '0;
    end else if (reg_wr) begin
      case (paddr[7:0])
        REG_IRQ_ENA: irq_ena <= pwdata[1:0];
        REG_SIZ:     cfg_siz <= pwdata[TAW:0];
        REG_OFF:     cfg_off <= pwdata[TAW+FRW-1:0];
        REG_STE:     cfg_ste <= pwdata[TAW+FRW-1:0];
        REG_BCF: begin
          cfg_ben <= pwdata[0];
          cfg_inf <= pwdata[1];
        end
        REG_BDL:     cfg_bdl <= pwdata[BNW-1:0];
        REG_BNM:     cfg_bnm <= pwdata[BNW-1:0];
        REG_MSK:     cfg_msk <= pwdata[DW-1:0];
        REG_VAL:     cfg_val <= pwdata[DW-1:0];
        default: ;
      endcase
    end
  end

  // one cycle control pulses
  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      sw_rst  <= 1'b0;
      ctl_str <= 1'b0;
      ctl_stp <= 1'b0;
      ctl_trg <= 1'b0;
    end else begin
      sw_rst  <= reg_wr && (paddr[7:0] == REG_CTL) && pwdata[CTL_RST];
      ctl_str <= reg_wr && (paddr[7:0] == REG_CTL) && pwdata[CTL_STR];
      ctl_stp <= reg_wr && (paddr[7:0] == REG_CTL) && pwdata[CTL_STP];
      ctl_trg <= reg_wr && (paddr[7:0] == REG_CTL) && pwdata[CTL_TRG];
    end
  end

  //////////////////////////////
  // interrupts
  always_comb begin
    evn = '0;
    evn[IRQ_TRG] = evn_trg;
    evn[IRQ_LST] = evn_lst;
  end

  always_ff @(posedge bus) begin
    if (ctl_rst || sw_rst) begin
      irq_sts <= '0;
      irq     <= 1'b0;
    end else begin
      if (reg_wr && (paddr[7:0] == REG_IRQ_STS)) begin
        irq_sts <= (irq_sts & ~pwdata[1:0]) | evn;  // new event beats clear
      end else begin
        irq_sts <= irq_sts | evn;
      end
      irq <= |(irq_sts & irq_ena);
    end
  end

  //////////////////////////////
  // read mux, combinational in access phase
  always_comb begin
    prdata = '0;
    if (tbl_sel) begin
      prdata[DW-1:0] = tbl_rdata;  // async ram read
    end else begin
      case (paddr[7:0])
        REG_CTL: begin
          prdata[STS_RUN] = (sts_state == ST_RUN);
          prdata[STS_ARM] = (sts_state == ST_ARMED);
          prdata[STS_DON] = (sts_state == ST_DONE);
        end
        REG_IRQ_ENA: prdata[1:0] = irq_ena;
        REG_IRQ_STS: prdata[1:0] = irq_sts;
        REG_SIZ:     prdata[TAW:0] = cfg_siz;
        REG_OFF:     prdata[TAW+FRW-1:0] = cfg_off;
        REG_STE:     prdata[TAW+FRW-1:0] = cfg_ste;
        REG_BCF:     prdata[1:0] = {cfg_inf, cfg_ben};
        REG_BDL:     prdata[BNW-1:0] = cfg_bdl;
        REG_BNM:     prdata[BNW-1:0] = cfg_bnm;
        REG_BLN:     prdata[BNW-1:0] = sts_bln;
        REG_BCN:     prdata[BNW-1:0] = sts_bcn;
        REG_MSK:     prdata[DW-1:0] = cfg_msk;
        REG_VAL:     prdata[DW-1:0] = cfg_val;
        default: ;  // unmapped reads 0
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/lg_fsm.sv
//////////////////////////////
// logic generator playback FSM
// idle, armed, run, done plus burst repeat
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lg_fsm (
  input  logic              bus,
  input  logic              ctl_rst,
  input  logic              sw_rst,
  input  logic              ctl_str,
  input  logic              ctl_stp,
  input  logic              ctl_trg,
  input  logic              cfg_ben,
  input  logic              cfg_inf,
  input  logic              bst_end,
  input  logic              rep_end,
  output logic              ptr_load,
  output logic              ptr_run,
  output logic              evn_trg,
  output lg_pkg::lg_state_t state
);
  import lg_pkg::*;

  lg_state_t nxt;
  logic      fin;  // last burst done, stop issuing

  assign fin = bst_end && cfg_ben && !cfg_inf && rep_end;

  always_comb begin
    nxt = state;
    case (state)
      ST_IDLE:  if (ctl_str) nxt = ST_ARMED;
      ST_ARMED: if (ctl_trg) nxt = ST_RUN;
      ST_RUN:   if (fin) nxt = ST_DONE;
      ST_DONE:  if (ctl_str) nxt = ST_ARMED;  // rearm
      default:  nxt = ST_IDLE;
    endcase
    if (ctl_stp) begin
      nxt = ST_IDLE;  // stop wins
    end
  end

  always_ff @(posedge bus) begin
    if (ctl_rst || sw_rst) begin
      state <= ST_IDLE;
    end else begin
      state <= nxt;
    end
  end

  assign ptr_run = (state == ST_RUN) && !ctl_stp;  // no new sample on stop
  assign evn_trg = (state == ST_ARMED) && ctl_trg && !ctl_stp;

  // reload on start, and between bursts unless last
  assign ptr_load = (((state == ST_IDLE) || (state == ST_DONE)) && ctl_str)
                  || (bst_end && cfg_ben && !fin);

endmodule

`default_nettype wire

// File: hdl/lg_ptr.sv
//////////////////////////////
// logic generator read pointer
// fixed point phase accumulator, burst counters
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lg_ptr #(
  parameter int unsigned TAW = 6,
  parameter int unsigned FRW = 8,
  parameter int unsigned BNW = 16
) (
  input  logic               bus,
  input  logic               ctl_rst,
  input  logic               ptr_load,
  input  logic               ptr_run,
  input  logic               adv,
  input  logic [TAW:0]       cfg_siz,
  input  logic [TAW+FRW-1:0] cfg_off,
  input  logic [TAW+FRW-1:0] cfg_ste,
  input  logic [BNW-1:0]     cfg_bdl,
  input  logic [BNW-1:0]     cfg_bnm,
  output logic [TAW-1:0]     rd_addr,
  output logic               rd_en,
  output logic               rd_last,
  output logic               bst_end,
  output logic               rep_end,
  output logic [BNW-1:0]     sts_bln,
  output logic [BNW-1:0]     sts_bcn
);
  localparam int unsigned PW = TAW + FRW;

  logic [PW-1:0]  ptr;   // integer.fraction
  logic [PW:0]    sum;   // one spare bit for wrap
  logic [PW:0]    lim;   // size scaled to fixed point
  logic [PW:0]    nxt;
  logic [BNW-1:0] bln;   // samples issued in this burst
  logic [BNW-1:0] bcn;   // bursts completed
  logic [BNW:0]   bcn_inc;
  logic           step;  // sample issued this cycle

  assign step = ptr_run && adv;  // stalls freeze everything

  assign sum = {1'b0, ptr} + {1'b0, cfg_ste};
  assign lim = {cfg_siz, {FRW{1'b0}}};
  assign nxt = (sum >= lim) ? (sum - lim) : sum;  // modulo table size

  // zero length means no block marks
  assign rd_last = (cfg_bdl != '0) && (bln == cfg_bdl - 1'b1);
  assign bst_end = step && rd_last;

  assign bcn_inc = {1'b0, bcn} + 1'b1;
  assign rep_end = (bcn_inc >= {1'b0, cfg_bnm});  // current burst is the last one

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      ptr <= '0;
      bln <= '0;
      bcn <= '0;
    end else begin
      if (ptr_load) begin
        ptr <= cfg_off;
      end else if (step) begin
        ptr <= nxt[PW-1:0];
      end
      if (ptr_load || bst_end) begin
        bln <= '0;
      end else if (step) begin
        bln <= bln + 1'b1;
      end
      if (bst_end) begin
        bcn <= bcn_inc[BNW-1:0];  // burst boundary counts
      end else if (ptr_load) begin
        bcn <= '0;  // fresh start
      end
    end
  end

  assign rd_addr = ptr[PW-1:FRW];  // integer part
  assign rd_en   = ptr_run;
  assign sts_bln = bln;
  assign sts_bcn = bcn;

endmodule

`default_nettype wire

// File: hdl/lg_tbl.sv
//////////////////////////////
// logic generator waveform table
// ram, mask stage, stream output register
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lg_tbl #(
  parameter int unsigned DW  = 8,
  parameter int unsigned TAW = 6
) (
  input  logic           bus,
  input  logic           ctl_rst,
  input  logic           tbl_we,
  input  logic [TAW-1:0] tbl_addr,
  input  logic [DW-1:0]  tbl_wdata,
  output logic [DW-1:0]  tbl_rdata,
  input  logic [TAW-1:0] rd_addr,
  input  logic           rd_en,
  input  logic           rd_last,
  output logic           adv,
  input  logic [DW-1:0]  cfg_msk,
  input  logic [DW-1:0]  cfg_val,
  output logic [DW-1:0]  sto_tdata,
  output logic           sto_tvalid,
  output logic           sto_tlast,
  input  logic           sto_tready
);
  logic [DW-1:0] mem [2**TAW];
  logic [DW-1:0] smp;  // masked sample

  always_ff @(posedge bus) begin
    if (tbl_we) begin
      mem[tbl_addr] <= tbl_wdata;
    end
  end

  assign tbl_rdata = mem[tbl_addr];  // apb side, async

  // mask 1 keeps table bit, mask 0 takes forced value
  assign smp = (mem[rd_addr] & cfg_msk) | (cfg_val & ~cfg_msk);
  assign adv = !sto_tvalid || sto_tready;  // empty or being taken

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      sto_tvalid <= 1'b0;
      sto_tlast  <= 1'b0;
    end else if (adv) begin
      sto_tvalid <= rd_en;
      sto_tlast  <= rd_en && rd_last;
    end
  end

  always_ff @(posedge bus) begin
    if (adv && rd_en) begin
      sto_tdata <= smp;
    end
  end

endmodule

`default_nettype wire

// File: hdl/lg_top.sv
//////////////////////////////
// logic pattern generator top
// apb port, irq, sample stream
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lg_top #(
  parameter int unsigned DW  = 8,   // sample width
  parameter int unsigned TAW = 6,   // table address width
  parameter int unsigned FRW = 8,   // pointer fraction
  parameter int unsigned BNW = 16   // burst counters
) (
  input  logic          bus,
  input  logic          ctl_rst,
  input  logic [11:0]   paddr,
  input  logic          psel,
  input  logic          penable,
  input  logic          pwrite,
  input  logic [31:0]   pwdata,
  output logic [31:0]   prdata,
  output logic          pready,
  output logic          pslverr,
  output logic          irq,
  output logic [DW-1:0] sto_tdata,
  output logic          sto_tvalid,
  output logic          sto_tlast,
  input  logic          sto_tready
);
  localparam int unsigned PW = TAW + FRW;

  logic              ctl_str, ctl_stp, ctl_trg, sw_rst;
  logic [TAW:0]      cfg_siz;
  logic [PW-1:0]     cfg_off, cfg_ste;
  logic [BNW-1:0]    cfg_bdl, cfg_bnm;
  logic              cfg_ben, cfg_inf;
  logic [DW-1:0]     cfg_msk, cfg_val;
  logic              tbl_we;
  logic [TAW-1:0]    tbl_addr, rd_addr;
  logic [DW-1:0]     tbl_wdata, tbl_rdata;
  lg_pkg::lg_state_t state;
  logic [BNW-1:0]    sts_bln, sts_bcn;
  logic              evn_trg, evn_lst;
  logic              ptr_load, ptr_run, bst_end, rep_end;
  logic              rd_en, rd_last, adv;

  // last beat taken
  assign evn_lst = sto_tvalid && sto_tready && sto_tlast;

  lg_regs #(.DW(DW), .TAW(TAW), .FRW(FRW), .BNW(BNW)) i_lg_regs (
    .bus, .ctl_rst, .paddr, .psel, .penable, .pwrite, .pwdata,
    .prdata, .pready, .pslverr, .irq,
    .ctl_str, .ctl_stp, .ctl_trg, .sw_rst,
    .cfg_siz, .cfg_off, .cfg_ste, .cfg_bdl, .cfg_ben, .cfg_inf, .cfg_bnm,
    .cfg_msk, .cfg_val, .tbl_we, .tbl_addr, .tbl_wdata, .tbl_rdata,
    .sts_state (state), .sts_bln, .sts_bcn, .evn_trg, .evn_lst
  );

  lg_fsm i_lg_fsm (
    .bus, .ctl_rst, .sw_rst, .ctl_str, .ctl_stp, .ctl_trg,
    .cfg_ben, .cfg_inf, .bst_end, .rep_end,
    .ptr_load, .ptr_run, .evn_trg, .state
  );

  lg_ptr #(.TAW(TAW), .FRW(FRW), .BNW(BNW)) i_lg_ptr (
    .bus, .ctl_rst, .ptr_load, .ptr_run, .adv,
    .cfg_siz, .cfg_off, .cfg_ste, .cfg_bdl, .cfg_bnm,
    .rd_addr, .rd_en, .rd_last, .bst_end, .rep_end, .sts_bln, .sts_bcn
  );

  lg_tbl #(.DW(DW), .TAW(TAW)) i_lg_tbl (
    .bus,
    .ctl_rst (ctl_rst | sw_rst),  // soft reset also empties output stage
    .tbl_we, .tbl_addr, .tbl_wdata, .tbl_rdata,
    .rd_addr, .rd_en, .rd_last, .adv, .cfg_msk, .cfg_val,
    .sto_tdata, .sto_tvalid, .sto_tlast, .sto_tready
  );

endmodule

`default_nettype wire

// File: bench/lg_tb.sv
//////////////////////////////
// logic generator testbench
// replays apb and stream vectors
// from a file, checks readback and beats
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lg_tb;

  logic        bus;
  logic        ctl_rst;
  logic [11:0] paddr;
  logic        psel, penable, pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready, pslverr, irq;
  logic [7:0]  sto_tdata;
  logic        sto_tvalid, sto_tlast, sto_tready;

  int          errs = 0;
  int          nvec = 0;       // vector lines after comments dropped
  int          fd;
  string       line;
  string       vec [$];
  logic [8:0]  beats [$];      // accepted beats as {last, data}
  logic        rdy_rand = 1'b0;      // random tready stalls
  logic        waiting_beat = 1'b0;  // blocked on the stream

  lg_top i_lg_top (
    .bus, .ctl_rst, .paddr, .psel, .penable, .pwrite, .pwdata,
    .prdata, .pready, .pslverr, .irq,
    .sto_tdata, .sto_tvalid, .sto_tlast, .sto_tready
  );

  //////////////////////////////
  // clock, ready, beat monitor
  initial begin
    bus = 1'b0;
    forever #5 bus = ~bus;  // 100 MHz
  end

  initial begin
    void'($urandom(32'h8832));
    sto_tready = 1'b0;
    forever begin
      @(posedge bus);
      sto_tready <= rdy_rand ? (($urandom % 3) != 0) : 1'b1;  // about 1 in 3 stalls
    end
  end

  // inputs only move on posedge, so a negedge hit means a transfer next edge
  always @(negedge bus) begin
    if (sto_tvalid && sto_tready) begin
      beats.push_back({sto_tlast, sto_tdata});
    end
  end

  //////////////////////////////
  // helpers
  task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      errs++;
      $display("Fail %0d ns: %s got %08h expected %08h", $time, msg, got, exp);
    end
  endtask

  task automatic write_reg(input logic [11:0] a, input logic [31:0] d);
    @(posedge bus);
    paddr   <= a;      // setup phase
    pwdata  <= d;
    pwrite  <= 1'b1;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge bus);
    penable <= 1'b1;   // access phase
    @(posedge bus);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic read_reg(input logic [11:0] a, output logic [31:0] d);
    @(posedge bus);
    paddr   <= a;
    pwrite  <= 1'b0;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge bus);
    penable <= 1'b1;
    @(negedge bus);    // prdata settled mid access cycle
    d = prdata;
    compare({30'd0, pready, pslverr}, 32'd2, "apb response");
    @(posedge bus);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic take_beat(input logic [7:0] d, input logic l);
    logic [8:0] b;
    waiting_beat = 1'b1;
    while (beats.size() == 0) begin
      @(negedge bus);
    end
    waiting_beat = 1'b0;
    b = beats.pop_front();
    compare({23'd0, b}, {23'd0, l, d}, "stream beat {last, data}");
  endtask

  task automatic wait_irq(input int cyc, input logic lvl);
    int n;
    n = 0;
    while (irq !== lvl && n < cyc) begin
      @(negedge bus);
      n++;
    end
    compare({31'd0, irq}, {31'd0, lvl}, "irq level");
  endtask

  // flush drops beats still in flight from a stop
  task automatic check_quiet(input int cyc, input logic flush);
    if (flush) begin
      repeat (3) @(negedge bus);
      beats.delete();
    end
    repeat (cyc) begin
      @(negedge bus);
      compare({31'd0, sto_tvalid}, 32'd0, "tvalid while idle");
    end
    compare(beats.size(), 32'd0, "beats after end of stream");
  endtask

  task automatic run_line(input string s);
    byte         op;
    logic [31:0] a, d, e, r;
    int          n;
    n = $sscanf(s, "%c %h %h %h", op, a, d, e);
    if (n != 4) begin
      errs++;
      $display("unreadable vector line: %s", s);
    end else begin
      case (op)
        "W": write_reg(a[11:0], d);
        "R": begin
          read_reg(a[11:0], r);
          compare(r, e, $sformatf("read of %03h", a[11:0]));
        end
        "S": take_beat(d[7:0], e[0]);
        "P": rdy_rand = d[0];
        "I": wait_irq(d, e[0]);
        "Z": check_quiet(d, e[0]);
        default: begin
          errs++;
          $display("unknown operation in vector line: %s", s);
        end
      endcase
    end
  endtask

  //////////////////////////////
  // main sequence
  initial begin
    ctl_rst = 1'b1;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    fd = $fopen("bench/lg_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open the vector file bench/lg_vectors.txt");
      $display("** FAIL **");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#") begin
          vec.push_back(line);
        end
      end
      $fclose(fd);
      nvec = vec.size();  // starts the watchdog
      repeat (16) @(posedge bus);
      ctl_rst <= 1'b0;
      foreach (vec[i]) begin
        run_line(vec[i]);
      end
      repeat (4) @(posedge bus);
      $display("vector lines: %0d, errors: %0d", nvec, errs);
      if (errs == 0) begin
        $display("** PASS **");
      end else begin
        $display("** FAIL **");
      end
    end
    $finish;
  end

  // watchdog allows 200 cycles per vector line plus reset
  initial begin
    wait (nvec > 0);
    repeat (16 + 200 * nvec) @(posedge bus);
    if (waiting_beat) begin
      $display("timeout: an expected stream beat never arrived");
    end else begin
      $display("timeout: the vector lines did not complete in time");
    end
    $display("vector lines: %0d, errors: %0d", nvec, errs);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/lg_vectors.txt
# op addr data expect, hex. W write, R read expect, S beat data/last, P ready mode (1 random)
# I wait data cycles for irq == expect, Z check idle for data cycles (expect 1 drops beats first)
R 000 00000000 00000000
R 00c 00000000 00000000
R 044 00000000 00000000
W 020 ffffffff 00000000
R 020 00000000 0000007f
W 030 ffffffff 00000000
R 030 00000000 00000003
W 03c ffffffff 00000000
R 03c 00000000 0000ffff
W 100 00000011 00000000
W 104 00000022 00000000
W 108 00000033 00000000
W 10c 00000044 00000000
W 110 00000055 00000000
R 104 00000000 00000022
R 110 00000000 00000055
# bursts of 4 from offset 3, size 5, step 1.0, two repetitions
W 008 00000003 00000000
W 020 00000005 00000000
W 024 00000300 00000000
W 028 00000100 00000000
W 030 00000001 00000000
W 034 00000004 00000000
W 03c 00000002 00000000
P 000 00000000 00000000
W 000 00000002 00000000
R 000 00000000 00000002
W 000 00000008 00000000
I 000 00000010 00000001
S 000 00000044 00000000
S 000 00000055 00000000
S 000 00000011 00000000
S 000 00000022 00000001
S 000 00000044 00000000
S 000 00000055 00000000
S 000 00000011 00000000
S 000 00000022 00000001
Z 000 00000014 00000000
R 000 00000000 00000004
R 044 00000000 00000002
R 00c 00000000 00000003
W 00c 00000003 00000000
I 000 00000010 00000000
R 00c 00000000 00000000
# step 0.5, mask f0 value 0a, random stalls
W 020 00000003 00000000
W 024 00000000 00000000
W 028 00000080 00000000
W 034 00000006 00000000
W 03c 00000001 00000000
W 050 000000f0 00000000
W 054 0000000a 00000000
P 000 00000001 00000000
W 000 00000002 00000000
W 000 00000008 00000000
S 000 0000001a 00000000
S 000 0000001a 00000000
S 000 0000002a 00000000
S 000 0000002a 00000000
S 000 0000003a 00000000
S 000 0000003a 00000001
Z 000 00000014 00000000
R 044 00000000 00000001
# free running, then stop and software reset
P 000 00000000 00000000
W 030 00000000 00000000
W 020 00000005 00000000
W 028 00000100 00000000
W 050 000000ff 00000000
W 000 00000002 00000000
W 000 00000008 00000000
S 000 00000011 00000000
S 000 00000022 00000000
S 000 00000033 00000000
W 000 00000004 00000000
Z 000 00000014 00000001
R 000 00000000 00000000
W 000 00000001 00000000
R 00c 00000000 00000000

// File: files.f
hdl/lg_pkg.sv
hdl/lg_regs.sv
hdl/lg_fsm.sv
hdl/lg_ptr.sv
hdl/lg_tbl.sv
hdl/lg_top.sv
bench/lg_tb.sv

// File: Makefile
# Verilator build and run of the logic pattern generator testbench

SIM   = verilator
FLAGS = --binary --timing -Wno-fatal -j 0
TOP   = lg_tb
FLIST = files.f
LOG   = sim.log
PASS  = ** PASS **

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM), run $(TOP), check $(LOG) for the pass line"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@grep -qF '$(PASS)' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
